/* mesh_noc_top.f */
source/noc_pkg.sv
source/flit_fifo.sv
source/router_input_port.sv
source/rr_arbiter.sv
source/mesh_router.sv
source/mesh_noc_top.sv
test/mesh_noc_assertions.sv
test/mesh_noc_tb.sv

/* test/mesh_noc_tb.sv */
module mesh_noc_tb;
    import noc_pkg::*;

    localparam int stall_wait_max = 400;         // cycles an endpoint may stay stalled
    localparam int drain_max      = 1000;        // cycles allowed for the network to empty

    logic  clk;
    logic  rst_n;
    logic  in_valid  [ne];
    flit_t in_flit   [ne];
    logic  in_stall  [ne];
    logic  out_valid [ne];
    flit_t out_flit  [ne];
    logic  out_stall [ne];

    integer seed = 32'h088e_004a;
    string  cur_test = "none";
    flit_t  pend_q [$];                          // injected, not yet delivered
    int     mismatch_count = 0;
    int     other_count = 0;
    int     inj_total = 0;
    int     rx_total = 0;
    int     held_rx = 0;                         // arrivals while endpoint 3 is stalled
    logic   hold_on = 1'b0;
    logic   watch_stall = 1'b0;
    logic   stall_seen = 1'b0;

    mesh_noc_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_stall  (in_stall),
        .out_valid (out_valid),
        .out_flit  (out_flit),
        .out_stall (out_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // row-major numbering, y times nx plus x
    function automatic int expected_endp(input flit_t f);
        return int'(f.dest_y) * nx + int'(f.dest_x);
    endfunction

    function automatic flit_t make_flit(input int dst, input int src,
                                        input logic [payload_w-1:0] payload);
        flit_t f;
        f.dest_x  = xw'(dst % nx);
        f.dest_y  = yw'(dst / nx);
        f.src_id  = new_w'(src);
        f.payload = payload;
        return f;
    endfunction

    // oldest pending flit for this destination and source
    function automatic int find_pending(input int port, input int src);
        flit_t c;
        for (int k = 0; k < pend_q.size(); k++) begin
            c = pend_q[k];
            if (expected_endp(c) == port && int'(c.src_id) == src) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic take_arrival(input int port, input flit_t got);
        int    idx;
        flit_t want;
        idx = find_pending(port, int'(got.src_id));
        rx_total++;
        if (hold_on && port == 3) begin
            held_rx++;
        end
        if (idx < 0) begin
            $display("%s: unexpected flit %0h at endpoint %0d, nothing pending from source %0d",
                     cur_test, got, port, got.src_id);
            other_count++;
        end else begin
            want = pend_q[idx];
            pend_q.delete(idx);
            check({cur_test, "/flit"}, want, got);
        end
    endtask

    // called at posedge + 10, returns at posedge + 10
    task automatic inject(input int src, input flit_t f);
        int waited;
        waited = 0;
        while (in_stall[src] && waited < stall_wait_max) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (in_stall[src]) begin
            $display("%s: endpoint %0d stayed stalled for %0d cycles, flit not sent",
                     cur_test, src, stall_wait_max);
            other_count++;
        end else begin
            pend_q.push_back(f);
            inj_total++;
            in_flit[src]  = f;
            in_valid[src] = 1'b1;                // one-cycle strobe
            @(posedge clk);
            #10;
            in_valid[src] = 1'b0;
        end
    endtask

    task automatic send_stream(input int src, input int dst, input int count);
        for (int k = 0; k < count; k++) begin
            inject(src, make_flit(dst, src, payload_w'((src << 12) | k)));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pend_q.size() != 0 && waited < drain_max) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (pend_q.size() != 0) begin
            $display("%s: %0d flits never arrived within %0d cycles",
                     cur_test, pend_q.size(), drain_max);
            other_count++;
            pend_q.delete();
        end
    endtask

    // scoreboard side, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int e = 0; e < ne; e++) begin
                if (out_valid[e]) begin
                    take_arrival(e, out_flit[e]);
                end
                if (watch_stall && in_stall[e]) begin
                    stall_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int e = 0; e < ne; e++) begin
            in_valid[e]  = 1'b0;
            in_flit[e]   = flit_gnd;
            out_stall[e] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;

        cur_test = "reset_idle";                 // quiet until first inject
        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            #10;
            for (int e = 0; e < ne; e++) begin
                check({cur_test, "/out_valid"}, 0, out_valid[e]);
                check({cur_test, "/in_stall"}, 0, in_stall[e]);
            end
        end

        cur_test = "all_pairs";                  // self traffic included
        for (int s = 0; s < ne; s++) begin
            for (int d = 0; d < ne; d++) begin
                inject(s, make_flit(d, s, payload_w'($random(seed))));
            end
        end
        drain();

        cur_test = "burst_order";                // fixed route keeps order
        for (int k = 0; k < 8; k++) begin
            inject(1, make_flit(2, 1, payload_w'($random(seed))));
        end
        drain();

        cur_test = "hotspot";
        stall_seen  = 1'b0;
        watch_stall = 1'b1;
        fork
            send_stream(0, 0, 12);
            send_stream(1, 0, 12);
            send_stream(2, 0, 12);
            send_stream(3, 0, 12);
        join
        drain();
        watch_stall = 1'b0;
        check({cur_test, "/stall_seen"}, 1, stall_seen);

        cur_test = "endpoint_stall";
        fork
            send_stream(0, 3, 6);
            send_stream(1, 3, 6);
            send_stream(2, 3, 6);
            begin
                repeat (2) begin
                    @(posedge clk);
                    #10;
                end
                held_rx      = 0;
                hold_on      = 1'b1;
                out_stall[3] = 1'b1;             // endpoint 3 refuses for 40 cycles
                repeat (40) begin
                    @(posedge clk);
                    #10;
                end
                hold_on      = 1'b0;
                out_stall[3] = 1'b0;
            end
        join
        drain();
        check({cur_test, "/at_most_one_held"}, 1, held_rx <= 1);

        check("delivered_count", inj_total, rx_total);
        $display("errors: %0d mismatches, %0d other failures, %0d flits sent, %0d received",
                 mismatch_count, other_count, inj_total, rx_total);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* test/mesh_noc_assertions.sv */
module mesh_router_checks #(
    parameter int my_x = 0,                      // router column
    parameter int my_y = 0                       // router row
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid  [noc_pkg::np],
    input logic                   out_valid [noc_pkg::np],
    input noc_pkg::flit_t         out_flit  [noc_pkg::np],
    input logic                   out_stall [noc_pkg::np],
    input logic [noc_pkg::np-1:0] pop,
    input logic [noc_pkg::np-1:0] grant_to  [noc_pkg::np]
);
    import noc_pkg::*;

    logic [fifo_aw:0] occ [np];                  // shadow fill of each input buffer
    logic [np-1:0]    grant_of [np];             // grant_of[i][o], outputs granting input i

    // a pop only happens on a non-empty buffer, so plain add/sub tracks it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < np; i++) begin
                occ[i] <= '0;
            end
        end else begin
            for (int i = 0; i < np; i++) begin
                occ[i] <= occ[i] + in_valid[i] - pop[i];
            end
        end
    end

    // arbiters seen from the input side
    always_comb begin
        for (int i = 0; i < np; i++) begin
            for (int o = 0; o < np; o++) begin
                grant_of[i][o] = grant_to[o][i];
            end
        end
    end

    a_local_dest: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid[port_local] |-> (out_flit[port_local].dest_x == xw'(my_x) &&
                                   out_flit[port_local].dest_y == yw'(my_y)))
        else $error("local output carries a flit addressed to another router");

    genvar g;
    generate
        for (g = 0; g < np; g++) begin : g_port
            a_no_full_write: assert property (@(posedge clk) disable iff (!rst_n)
                in_valid[g] |-> occ[g] < (fifo_aw + 1)'(fifo_depth))
                else $error("flit written into a full input buffer on port %0d", g);
            a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                out_stall[g] |=> !out_valid[g])
                else $error("output %0d launched a flit after seeing stall", g);
            a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(grant_of[g]))
                else $error("input %0d granted by more than one output arbiter", g);
        end
    endgenerate

endmodule

bind mesh_router mesh_router_checks #(
    .my_x (my_x),
    .my_y (my_y)
) u_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_stall (out_stall),
    .pop       (pop),
    .grant_to  (grant_to)
);

/* source/mesh_noc_top.sv */
module mesh_noc_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid  [noc_pkg::ne],
    input  noc_pkg::flit_t in_flit   [noc_pkg::ne],
    output logic           in_stall  [noc_pkg::ne],
    output logic           out_valid [noc_pkg::ne],
    output noc_pkg::flit_t out_flit  [noc_pkg::ne],
    input  logic           out_stall [noc_pkg::ne]
);
    import noc_pkg::*;

    // all router ports, first index is the router id
    logic  r_in_valid  [ne][np];
    flit_t r_in_flit   [ne][np];
    logic  r_in_stall  [ne][np];                 // edge entries stay unread
    logic  r_out_valid [ne][np];
    flit_t r_out_flit  [ne][np];
    logic  r_out_stall [ne][np];

    genvar x, y;
    generate
        for (y = 0; y < ny; y++) begin : g_y
            for (x = 0; x < nx; x++) begin : g_x
                mesh_router #(
                    .my_x (x),
                    .my_y (y)
                ) u_router (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .in_valid  (r_in_valid[endp_id_of(x, y)]),
                    .in_flit   (r_in_flit[endp_id_of(x, y)]),
                    .in_stall  (r_in_stall[endp_id_of(x, y)]),
                    .out_valid (r_out_valid[endp_id_of(x, y)]),
                    .out_flit  (r_out_flit[endp_id_of(x, y)]),
                    .out_stall (r_out_stall[endp_id_of(x, y)])
                );

                // east side, neighbour x+1 feeds us through its west output
                if (x < nx - 1) begin : g_east
                    assign r_in_valid[endp_id_of(x, y)][port_east]  = r_out_valid[endp_id_of(x + 1, y)][port_west];
                    assign r_in_flit[endp_id_of(x, y)][port_east]   = r_out_flit[endp_id_of(x + 1, y)][port_west];
                    assign r_out_stall[endp_id_of(x, y)][port_east] = r_in_stall[endp_id_of(x + 1, y)][port_west];
                end else begin : g_east_gnd
                    assign r_in_valid[endp_id_of(x, y)][port_east]  = 1'b0;
                    assign r_in_flit[endp_id_of(x, y)][port_east]   = flit_gnd;
                    assign r_out_stall[endp_id_of(x, y)][port_east] = 1'b0;
                end

                // north side, neighbour y-1 sends south
                if (y > 0) begin : g_north
                    assign r_in_valid[endp_id_of(x, y)][port_north]  = r_out_valid[endp_id_of(x, y - 1)][port_south];
                    assign r_in_flit[endp_id_of(x, y)][port_north]   = r_out_flit[endp_id_of(x, y - 1)][port_south];
                    assign r_out_stall[endp_id_of(x, y)][port_north] = r_in_stall[endp_id_of(x, y - 1)][port_south];
                end else begin : g_north_gnd
                    assign r_in_valid[endp_id_of(x, y)][port_north]  = 1'b0;
                    assign r_in_flit[endp_id_of(x, y)][port_north]   = flit_gnd;
                    assign r_out_stall[endp_id_of(x, y)][port_north] = 1'b0;
                end

                // west side
                if (x > 0) begin : g_west
                    assign r_in_valid[endp_id_of(x, y)][port_west]  = r_out_valid[endp_id_of(x - 1, y)][port_east];
                    assign r_in_flit[endp_id_of(x, y)][port_west]   = r_out_flit[endp_id_of(x - 1, y)][port_east];
                    assign r_out_stall[endp_id_of(x, y)][port_west] = r_in_stall[endp_id_of(x - 1, y)][port_east];
                end else begin : g_west_gnd
                    assign r_in_valid[endp_id_of(x, y)][port_west]  = 1'b0;
                    assign r_in_flit[endp_id_of(x, y)][port_west]   = flit_gnd;
                    assign r_out_stall[endp_id_of(x, y)][port_west] = 1'b0;
                end

                // south side
                if (y < ny - 1) begin : g_south
                    assign r_in_valid[endp_id_of(x, y)][port_south]  = r_out_valid[endp_id_of(x, y + 1)][port_north];
                    assign r_in_flit[endp_id_of(x, y)][port_south]   = r_out_flit[endp_id_of(x, y + 1)][port_north];
                    assign r_out_stall[endp_id_of(x, y)][port_south] = r_in_stall[endp_id_of(x, y + 1)][port_north];
                end else begin : g_south_gnd
                    assign r_in_valid[endp_id_of(x, y)][port_south]  = 1'b0;
                    assign r_in_flit[endp_id_of(x, y)][port_south]   = flit_gnd;
                    assign r_out_stall[endp_id_of(x, y)][port_south] = 1'b0;
                end

                // local port to its endpoint
                assign r_in_valid[endp_id_of(x, y)][port_local]  = in_valid[endp_id_of(x, y)];
                assign r_in_flit[endp_id_of(x, y)][port_local]   = in_flit[endp_id_of(x, y)];
                assign in_stall[endp_id_of(x, y)]                = r_in_stall[endp_id_of(x, y)][port_local];
                assign out_valid[endp_id_of(x, y)]               = r_out_valid[endp_id_of(x, y)][port_local];
                assign out_flit[endp_id_of(x, y)]                = r_out_flit[endp_id_of(x, y)][port_local];
                assign r_out_stall[endp_id_of(x, y)][port_local] = out_stall[endp_id_of(x, y)];
            end
        end
    endgenerate

endmodule

/* source/mesh_router.sv */
module mesh_router #(
    parameter int my_x = 0,                      // router column
    parameter int my_y = 0                       // router row
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid  [noc_pkg::np],
    input  noc_pkg::flit_t in_flit   [noc_pkg::np],
    output logic           in_stall  [noc_pkg::np],
    output logic           out_valid [noc_pkg::np],
    output noc_pkg::flit_t out_flit  [noc_pkg::np],
    input  logic           out_stall [noc_pkg::np]
);
    import noc_pkg::*;

    flit_t         head_flit [np];               // head of each input buffer
    logic [np-1:0] req       [np];               // req[i][o], input i wants output o
    logic [np-1:0] grant_to  [np];               // grant_to[o][i], one-hot per output
    logic [np-1:0] pop;                          // pop[i], input i was granted

    genvar i, o;

    // input side
    generate
        for (i = 0; i < np; i++) begin : g_in
            router_input_port #(
                .my_x (my_x),
                .my_y (my_y)
            ) u_in_port (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid[i]),
                .in_flit   (in_flit[i]),
                .in_stall  (in_stall[i]),
                .grant     (pop[i]),
                .head_flit (head_flit[i]),
                .req       (req[i])
            );
        end
    endgenerate

    // a request is one-hot so at most one output grants each input
    always_comb begin
        pop = '0;
        for (int ko = 0; ko < np; ko++) begin
            for (int ki = 0; ki < np; ki++) begin
                pop[ki] = pop[ki] | grant_to[ko][ki];
            end
        end
    end

    // output side, arbiter + crossbar column + output register
    generate
        for (o = 0; o < np; o++) begin : g_out
            logic [np-1:0] req_col;              // inputs asking for this output
            flit_t         sel_flit;             // crossbar result

            always_comb begin
                for (int k = 0; k < np; k++) begin
                    req_col[k] = req[k][o];
                end
            end

            rr_arbiter u_arb (
                .clk    (clk),
                .rst_n  (rst_n),
                .req    (req_col),
                .enable (!out_stall[o]),         // hold while downstream is full
                .grant  (grant_to[o])
            );

            always_comb begin
                sel_flit = flit_gnd;
                for (int k = 0; k < np; k++) begin
                    if (grant_to[o][k]) begin
                        sel_flit = head_flit[k];
                    end
                end
            end

            // launch one cycle after the grant
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    out_valid[o] <= 1'b0;
                end else begin
                    out_valid[o] <= |grant_to[o];
                end
            end

            always_ff @(posedge clk) begin
                if (|grant_to[o]) begin
                    out_flit[o] <= sel_flit;     // payload register, qualified by out_valid
                end
            end
        end
    endgenerate

endmodule

/* source/rr_arbiter.sv */
module rr_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [noc_pkg::np-1:0] req,
    input  logic                   enable,
    output logic [noc_pkg::np-1:0] grant
);
    import noc_pkg::*;

    logic [pw-1:0] ptr;                          // highest priority requester
    logic [np-1:0] mask;                         // requesters at or above ptr
    logic [np-1:0] sel_req;                      // requests seen by the encoder
    logic [pw-1:0] winner;

    always_comb begin
        for (int i = 0; i < np; i++) begin
            mask[i] = (i >= ptr);
        end
        // wrap around when nobody at or above ptr asks
        sel_req = (|(req & mask)) ? (req & mask) : req;
        winner = '0;
        for (int i = np - 1; i >= 0; i--) begin
            if (sel_req[i]) begin
                winner = pw'(i);                 // lowest set bit wins
            end
        end
        grant = '0;
        if (enable && |req) begin
            grant[winner] = 1'b1;
        end
    end

    // pointer only moves when a grant goes out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (|grant) begin
            ptr <= (winner == pw'(np - 1)) ? '0 : winner + 1'b1;
        end
    end

endmodule

/* source/router_input_port.sv */
module router_input_port #(
    parameter int my_x = 0,                      // router column
    parameter int my_y = 0                       // router row
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  noc_pkg::flit_t         in_flit,
    output logic                   in_stall,
    input  logic                   grant,
    output noc_pkg::flit_t         head_flit,
    output logic [noc_pkg::np-1:0] req
);
    import noc_pkg::*;

    logic empty;                                 // nothing waiting at the head
    logic x_done;                                // column reached
    logic y_done;                                // row reached

    // every arriving flit is buffered, link protocol keeps it from overflowing
    flit_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (in_valid),
        .wr_flit   (in_flit),
        .rd        (grant),                      // grant pops the head
        .head_flit (head_flit),
        .empty     (empty),
        .stall     (in_stall)
    );

    assign x_done = (head_flit.dest_x == xw'(my_x));
    assign y_done = (head_flit.dest_y == yw'(my_y));

    // XY routing, x first then y, one-hot request
    always_comb begin
        req = '0;
        if (!empty) begin
            if (!x_done) begin
                if (head_flit.dest_x > xw'(my_x)) begin
                    req[port_east] = 1'b1;       // destination further right
                end else begin
                    req[port_west] = 1'b1;
                end
            end else if (!y_done) begin
                if (head_flit.dest_y > yw'(my_y)) begin
                    req[port_south] = 1'b1;      // rows grow southward
                end else begin
                    req[port_north] = 1'b1;
                end
            end else begin
                req[port_local] = 1'b1;          // arrived, eject
            end
        end
    end

endmodule

/* source/flit_fifo.sv */
module flit_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr,
    input  noc_pkg::flit_t wr_flit,
    input  logic           rd,
    output noc_pkg::flit_t head_flit,
    output logic           empty,
    output logic           stall
);
    import noc_pkg::*;

    flit_t              mem [fifo_depth];        // flit storage
    logic [fifo_aw-1:0] wr_ptr;                  // next free slot
    logic [fifo_aw-1:0] rd_ptr;                  // oldest entry
    logic [fifo_aw:0]   count;                   // occupancy, 0..fifo_depth
    logic               do_rd;                   // pop qualified by non-empty

    assign do_rd = rd && !empty;

    // storage has no reset, contents are qualified by count
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_flit;              // senders respect stall, never full here
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == fifo_aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == fifo_aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr, do_rd})
                2'b10:   count <= count + 1'b1;  // push only
                2'b01:   count <= count - 1'b1;  // pop only
                default: count <= count;         // idle or push+pop
            endcase
        end
    end

    assign head_flit = mem[rd_ptr];              // valid one cycle after write
    assign empty     = (count == '0);

    // raised early, a flit may still be on the link
    assign stall = (count >= (fifo_aw + 1)'(fifo_stall_lvl));

endmodule

/* source/noc_pkg.sv */
package noc_pkg;

    // mesh geometry
    localparam int nx = 2;                       // routers along x
    localparam int ny = 2;                       // routers along y
    localparam int ne = nx * ny;                 // one endpoint per router

    // address field widths
    localparam int xw = $clog2(nx);              // dest_x bits
    localparam int yw = $clog2(ny);              // dest_y bits
    localparam int new_w = $clog2(ne);           // endpoint id bits
    localparam int payload_w = 16;

    // router ports
    localparam int np = 5;                       // local + four neighbours
    localparam int pw = $clog2(np);              // port index bits

    localparam int port_local = 0;
    localparam int port_east  = 1;               // towards x+1
    localparam int port_north = 2;               // towards y-1
    localparam int port_west  = 3;               // towards x-1
    localparam int port_south = 4;               // towards y+1

    // input buffering
    localparam int fifo_depth = 4;               // entries per input port
    localparam int fifo_aw = $clog2(fifo_depth); // pointer bits
    localparam int fifo_stall_lvl = fifo_depth - 1; // one slot kept for a flit in flight

    // single-flit packet, header fields on top
    typedef struct packed {
        logic [xw-1:0]        dest_x;
        logic [yw-1:0]        dest_y;
        logic [new_w-1:0]     src_id;            // injecting endpoint
        logic [payload_w-1:0] payload;
    } flit_t;

    // driven onto unused mesh edge links
    localparam flit_t flit_gnd = '0;

    // row-major endpoint numbering
    function automatic int endp_id_of(input int x, input int y);
        return y * nx + x;
    endfunction

endpackage
